// ==== Makefile ====
TOP = mlsdTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sources.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f sources.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== channelEstRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

module channelEstRegs #(
	parameter int estDepth = 3
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic estWrEn,
	input wire mlsdPkg::tapAddrT estAddr,
	input wire mlsdPkg::estT estData,
	input wire logic cfgWrEn,
	input wire logic cfgEnable,
	output mlsdPkg::estT [estDepth-1:0] taps,
	output logic mlsdEnable
);

	logic addrOk; // tap index inside the estimate

	assign addrOk = int'(estAddr) < estDepth;

	// ####################
	// tap storage
	// ####################

	always_ff @(posedge clk) begin
		if (rst) begin
			taps <= '0;
		end else if (estWrEn && addrOk) begin
			taps[estAddr] <= estData;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mlsdEnable <= 1'b0;
		end else if (cfgWrEn) begin
			mlsdEnable <= cfgEnable;
		end
	end

	// the two strobes share one write port upstream
	wrStrobeExclusive: assert property (@(posedge clk) disable iff (rst)
		!($rose(estWrEn) && $rose(cfgWrEn)))
		else $error("tap and enable writes in the same cycle");

endmodule

`default_nettype wire

// ==== mlsdDecision.sv ====
`timescale 1ns/1ps
`default_nettype none

module mlsdDecision #(
	parameter int numChannels = 4,
	parameter int seqLength = 2,
	parameter int bufferDepth = 3,
	parameter int centerBuffer = 1
) (
	input wire logic clk,
	input wire logic rst,
	input wire mlsdPkg::codeT [numChannels*bufferDepth-1:0] flatCodes,
	input wire mlsdPkg::codeT [1:0][numChannels-1:0][seqLength-1:0] estSeq,
	input wire logic [numChannels-1:0] centerBits,
	input wire logic mlsdEnable,
	output logic [numChannels-1:0] predictBits,
	output logic [numChannels-1:0] flips
);

	localparam int centerBase = centerBuffer * numChannels;

	mlsdPkg::energyT [1:0][numChannels-1:0] energy;
	logic [numChannels-1:0] decided;
	logic [numChannels-1:0] nextFlips;

	// sum of absolute errors, clipped to the energy range
	function automatic mlsdPkg::energyT errEnergy(
		input mlsdPkg::codeT [numChannels*bufferDepth-1:0] rx,
		input mlsdPkg::codeT [seqLength-1:0] est,
		input int base
	);
		int acc;
		int diff;
		acc = 0;
		for (int m = 0; m < seqLength; m++) begin
			diff = int'(rx[base + m]) - int'(est[m]);
			if (diff < 0) begin
				diff = -diff;
			end
			acc += diff;
		end
		if (acc > mlsdPkg::energyMax) begin
			acc = mlsdPkg::energyMax;
		end
		return mlsdPkg::energyT'(acc);
	endfunction

	// ####################
	// scoring
	// ####################

	always_comb begin
		for (int i = 0; i < numChannels; i++) begin
			for (int h = 0; h < 2; h++) begin
				energy[h][i] = errEnergy(flatCodes, estSeq[h][i], centerBase + i);
			end
			if (mlsdEnable) begin
				decided[i] = energy[1][i] < energy[0][i]; // tie stays at 0
			end else begin
				decided[i] = centerBits[i]; // bypass
			end
			nextFlips[i] = decided[i] ^ centerBits[i];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			predictBits <= '0;
			flips <= '0;
		end else begin
			predictBits <= decided;
			flips <= nextFlips;
		end
	end

	// bypass never overrides the slicer
	noFlipWhenOff: assert property (@(posedge clk) disable iff (rst)
		!mlsdEnable |=> (flips == '0))
		else $error("flip reported while detector disabled");

endmodule

`default_nettype wire

// ==== mlsdPkg.sv ====
`default_nettype none

package mlsdPkg;

	// ####################
	// data widths
	// ####################

	localparam int codeWidth = 8; // one adc sample
	typedef logic signed [codeWidth-1:0] codeT;

	localparam int estWidth = 8;
	typedef logic signed [estWidth-1:0] estT;

	// error energies are unsigned and clip at the top
	localparam int energyWidth = 12;
	typedef logic [energyWidth-1:0] energyT;

	localparam int tapAddrWidth = 4; // room for 16 taps
	typedef logic [tapAddrWidth-1:0] tapAddrT;

	// ####################
	// saturation limits
	// ####################

	localparam int codeMax = 2**(codeWidth-1) - 1;
	localparam int codeMin = -(2**(codeWidth-1));
	localparam int energyMax = 2**energyWidth - 1;

endpackage

`default_nettype wire

// ==== mlsdTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mlsdTb;

	localparam int numChannels = 4;
	localparam int latency = 4; // word in, decision out
	localparam int waitLimit = 40;
	localparam int lineLimit = 1000;
	localparam string traceName = "mlsdTrace.txt";

	typedef logic [numChannels-1:0] laneT;

	logic clk;
	logic rst;
	mlsdPkg::codeT [numChannels-1:0] codes;
	laneT bits;
	logic estWrEn;
	mlsdPkg::tapAddrT estAddr;
	mlsdPkg::estT estData;
	logic cfgWrEn;
	logic cfgEnable;
	laneT predictBits;
	laneT flips;

	int cycle; // rising edges since reset release
	int dueQ[$];
	laneT expBitsQ[$];
	laneT expFlipsQ[$];
	int checks;

	int fd;
	int lineNo;
	int n;
	int waitCount;
	string line;
	string op;
	logic [31:0] v [7];

	mlsdTop u_mlsdTop (
		.clk(clk),
		.rst(rst),
		.codes(codes),
		.bits(bits),
		.estWrEn(estWrEn),
		.estAddr(estAddr),
		.estData(estData),
		.cfgWrEn(cfgWrEn),
		.cfgEnable(cfgEnable),
		.predictBits(predictBits),
		.flips(flips)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ####################
	// checking
	// ####################

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic checkBits(input laneT got, input laneT exp);
		if (got !== exp) begin
			abortRun($sformatf("ERR %0t: predictBits is %h, expected %h", $time, got, exp));
		end
	endtask

	task automatic checkFlips(input laneT got, input laneT exp);
		if (got !== exp) begin
			abortRun($sformatf("ERR %0t: flips is %h, expected %h", $time, got, exp));
		end
	endtask

	// compare whatever result falls due in this cycle
	task automatic checkDue();
		if (dueQ.size() > 0 && dueQ[0] == cycle) begin
			checkBits(predictBits, expBitsQ[0]);
			checkFlips(flips, expFlipsQ[0]);
			void'(dueQ.pop_front());
			void'(expBitsQ.pop_front());
			void'(expFlipsQ.pop_front());
			checks++;
		end
	endtask

	task automatic nextCycle();
		@(posedge clk);
		cycle++;
		#1;
		checkDue();
	endtask

	// ####################
	// trace replay
	// ####################

	task automatic applyLine(input string text);
		estWrEn = 1'b0; // strobes last one cycle
		cfgWrEn = 1'b0;
		if (op == "T") begin
			n = $sscanf(text, "%s %h %h", op, v[0], v[1]);
			if (n != 3) begin
				abortRun($sformatf("trace line %0d is not a valid tap write", lineNo));
			end
			estWrEn = 1'b1;
			estAddr = mlsdPkg::tapAddrT'(v[0]);
			estData = mlsdPkg::estT'(v[1]);
		end else if (op == "E") begin
			n = $sscanf(text, "%s %h", op, v[0]);
			if (n != 2) begin
				abortRun($sformatf("trace line %0d is not a valid enable write", lineNo));
			end
			cfgWrEn = 1'b1;
			cfgEnable = v[0][0];
		end else if (op == "D") begin
			n = $sscanf(text, "%s %h %h %h %h %h %h %h", op,
				v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
			if (n != 8) begin
				abortRun($sformatf("trace line %0d is not a valid data word", lineNo));
			end
			for (int i = 0; i < numChannels; i++) begin
				codes[i] = mlsdPkg::codeT'(v[i]);
			end
			bits = laneT'(v[4]);
			dueQ.push_back(cycle + latency);
			expBitsQ.push_back(laneT'(v[5]));
			expFlipsQ.push_back(laneT'(v[6]));
		end else if (op != "I") begin
			abortRun($sformatf("trace line %0d has unknown operation %s", lineNo, op));
		end
	endtask

	initial begin
		rst = 1'b1;
		codes = '0;
		bits = '0;
		estWrEn = 1'b0;
		estAddr = '0;
		estData = '0;
		cfgWrEn = 1'b0;
		cfgEnable = 1'b0;
		cycle = 0;
		checks = 0;
		lineNo = 0;

		repeat (2) @(posedge clk);
		#1 rst = 1'b0;

		waitCount = 0;
		while (rst) begin
			if (waitCount >= waitLimit) begin
				abortRun("reset never released");
			end
			@(posedge clk);
			waitCount++;
		end

		fd = $fopen(traceName, "r");
		if (fd == 0) begin
			abortRun("cannot open the trace file mlsdTrace.txt");
		end

		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			lineNo++;
			if (lineNo > lineLimit) begin
				abortRun("trace file is too long");
			end
			// blank lines and comments take no cycle
			if ($sscanf(line, "%s", op) == 1 && op.getc(0) != "#") begin
				nextCycle();
				applyLine(line);
			end
		end
		$fclose(fd);

		// hold the last word while the pipeline drains
		waitCount = 0;
		while (dueQ.size() > 0) begin
			if (waitCount >= waitLimit) begin
				abortRun("timed out waiting for the last results");
			end
			nextCycle();
			estWrEn = 1'b0;
			cfgWrEn = 1'b0;
			waitCount++;
		end

		if (checks > 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			abortRun("the trace held no data words to check");
		end
	end

endmodule

`default_nettype wire

// ==== mlsdTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module mlsdTop #(
	parameter int numChannels = 4,
	parameter int estDepth = 3,
	parameter int seqLength = 2
) (
	input wire logic clk,
	input wire logic rst,
	input wire mlsdPkg::codeT [numChannels-1:0] codes,
	input wire logic [numChannels-1:0] bits,
	input wire logic estWrEn,
	input wire mlsdPkg::tapAddrT estAddr,
	input wire mlsdPkg::estT estData,
	input wire logic cfgWrEn,
	input wire logic cfgEnable,
	output logic [numChannels-1:0] predictBits,
	output logic [numChannels-1:0] flips
);

	// words needed on each side of the center word
	localparam int numPastBuffers = (estDepth - 1 + numChannels - 1) / numChannels;
	localparam int numFutureBuffers = (seqLength - 1 + numChannels - 1) / numChannels;
	localparam int bufferDepth = numPastBuffers + numFutureBuffers + 1;

	logic [numChannels*bufferDepth-1:0] flatBits;
	mlsdPkg::codeT [numChannels*bufferDepth-1:0] flatCodes;
	mlsdPkg::estT [estDepth-1:0] taps;
	logic mlsdEnable;
	mlsdPkg::codeT [1:0][numChannels-1:0][seqLength-1:0] estSeq;
	logic [numChannels-1:0] centerBits;

	channelEstRegs #(.estDepth(estDepth)) u_channelEstRegs (
		.clk(clk),
		.rst(rst),
		.estWrEn(estWrEn),
		.estAddr(estAddr),
		.estData(estData),
		.cfgWrEn(cfgWrEn),
		.cfgEnable(cfgEnable),
		.taps(taps),
		.mlsdEnable(mlsdEnable)
	);

	windowBuffer #(
		.numChannels(numChannels),
		.width(1),
		.depth(bufferDepth),
		.inDelay(0)
	) bitWin (
		.clk(clk),
		.rst(rst),
		.din(bits),
		.flatOut(flatBits)
	);

	// one extra stage lines the codes up with the registered estimates
	windowBuffer #(
		.numChannels(numChannels),
		.width(mlsdPkg::codeWidth),
		.depth(bufferDepth),
		.inDelay(1)
	) codeWin (
		.clk(clk),
		.rst(rst),
		.din(codes),
		.flatOut(flatCodes)
	);

	potentialCodesGen #(
		.numChannels(numChannels),
		.estDepth(estDepth),
		.seqLength(seqLength),
		.bufferDepth(bufferDepth),
		.centerBuffer(numPastBuffers)
	) u_potentialCodesGen (
		.clk(clk),
		.rst(rst),
		.flatBits(flatBits),
		.taps(taps),
		.estSeq(estSeq),
		.centerBits(centerBits)
	);

	mlsdDecision #(
		.numChannels(numChannels),
		.seqLength(seqLength),
		.bufferDepth(bufferDepth),
		.centerBuffer(numPastBuffers)
	) u_mlsdDecision (
		.clk(clk),
		.rst(rst),
		.flatCodes(flatCodes),
		.estSeq(estSeq),
		.centerBits(centerBits),
		.mlsdEnable(mlsdEnable),
		.predictBits(predictBits),
		.flips(flips)
	);

endmodule

`default_nettype wire

// ==== mlsdTrace.txt ====
# T addr data | E enable | I idle | D code0 code1 code2 code3 bits expBits expFlips
# hex values, lane i is bit i; non-data lines hold the last word
# bypass with zero taps
D 11 22 33 44 5 5 0
D 80 7f 00 ff a a 0
D fc fc fc fc 0 0 0
T 0 01
T 1 02
T 2 01
E 1
I
# clean convolved stream, taps 1 2 1
D fe 02 04 04 f f 0
D 02 fe fe 02 c c 0
D 04 04 02 fe 3 3 0
# single tentative bit errors
D fe 02 04 02 5 7 2
D fe fc fc fe a 8 2
D 02 04 02 fe b 3 8
D fc fc fc fc 0 0 0
# tie in lane 0
D fd fe fc fc 0 0 0
D fc fc fc fc 0 0 0
# out of range tap write
I
T 3 7f
I
D fe 02 04 04 f f 0
D 04 04 02 fe 3 3 0
D fc fc fc fc 0 0 0
# tap 0 raised to 64
I
T 0 40
I
D fe 02 04 04 f 0 f
D 04 04 02 fe 3 e d
D fc fc fc fc 0 f f
# saturated estimates and full-scale codes
I
T 1 7f
D 7f 7f 7f 7f f 7 8
D 80 80 80 80 0 0 0

// ==== potentialCodesGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module potentialCodesGen #(
	parameter int numChannels = 4,
	parameter int estDepth = 3,
	parameter int seqLength = 2,
	parameter int bufferDepth = 3,
	parameter int centerBuffer = 1
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic [numChannels*bufferDepth-1:0] flatBits,
	input wire mlsdPkg::estT [estDepth-1:0] taps,
	output mlsdPkg::codeT [1:0][numChannels-1:0][seqLength-1:0] estSeq,
	output logic [numChannels-1:0] centerBits
);

	localparam int flatLen = numChannels * bufferDepth;
	localparam int centerBase = centerBuffer * numChannels;

	mlsdPkg::codeT [1:0][numChannels-1:0][seqLength-1:0] nextSeq;
	logic [numChannels-1:0] nextCenter;

	function automatic mlsdPkg::codeT satCode(input int v);
		if (v > mlsdPkg::codeMax) begin
			return mlsdPkg::codeT'(mlsdPkg::codeMax);
		end else if (v < mlsdPkg::codeMin) begin
			return mlsdPkg::codeT'(mlsdPkg::codeMin);
		end
		return mlsdPkg::codeT'(v);
	endfunction

	// estimated code at pos, with the center sample forced to hyp
	function automatic mlsdPkg::codeT estimateAt(
		input logic [flatLen-1:0] win,
		input mlsdPkg::estT [estDepth-1:0] tapVals,
		input int pos,
		input int center,
		input logic hyp
	);
		int acc;
		int k;
		logic b;
		acc = 0;
		for (int j = 0; j < estDepth; j++) begin
			k = pos - j;
			b = (k == center) ? hyp : win[k];
			acc += b ? int'(tapVals[j]) : -int'(tapVals[j]); // +1 / -1 signs
		end
		return satCode(acc);
	endfunction

	// ####################
	// hypothesis sequences
	// ####################

	always_comb begin
		for (int i = 0; i < numChannels; i++) begin
			nextCenter[i] = flatBits[centerBase + i];
			for (int m = 0; m < seqLength; m++) begin
				for (int h = 0; h < 2; h++) begin
					nextSeq[h][i][m] = estimateAt(flatBits, taps, centerBase + i + m,
						centerBase + i, h[0]);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		estSeq <= nextSeq;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			centerBits <= '0;
		end else begin
			centerBits <= nextCenter;
		end
	end

	// a silent channel estimate predicts silence
	zeroTapsZeroSeq: assert property (@(posedge clk) disable iff (rst)
		(taps == '0) |=> (estSeq == '0))
		else $error("nonzero estimate from zero taps");

endmodule

`default_nettype wire

// ==== sources.f ====
mlsdPkg.sv
windowBuffer.sv
channelEstRegs.sv
potentialCodesGen.sv
mlsdDecision.sv
mlsdTop.sv
mlsdTb.sv

// ==== windowBuffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module windowBuffer #(
	parameter int numChannels = 4,
	parameter int width = 8,
	parameter int depth = 3,
	parameter int inDelay = 0
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic [numChannels-1:0][width-1:0] din,
	output logic [numChannels*depth-1:0][width-1:0] flatOut
);

	localparam int chainLen = depth + inDelay;

	// chain[0] is the oldest word, the input enters at the top
	// the upper inDelay entries are pure delay, the lower depth entries form the window
	logic [numChannels-1:0][width-1:0] chain [chainLen];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k < chainLen; k++) begin
				chain[k] <= '0;
			end
		end else begin
			for (int k = 0; k < chainLen - 1; k++) begin
				chain[k] <= chain[k+1];
			end
			chain[chainLen-1] <= din;
		end
	end

	// flatten in time order, lane 0 of the oldest word first
	for (genvar d = 0; d < depth; d++) begin : gWord
		for (genvar c = 0; c < numChannels; c++) begin : gLane
			assign flatOut[d*numChannels + c] = chain[d][c];
		end
	end

endmodule

`default_nettype wire
